// ==== source/heap_pkg.sv ====
////////////////////
// heap allocator package
// word sizes, tag masks, reserved words and the
// tagged-word union shared by the heap allocator blocks
////////////////////

package heap_pkg;

    // sizes
    localparam int DATA_SZ = 16;                   // bits per word
    localparam int ADDR_SZ = 8;                    // bits per cell index
    localparam int MEM_MAX = 1 << ADDR_SZ;         // cells in the heap

    // tag masks
    localparam logic [DATA_SZ-1:0] DIR_TAG = 16'h8000;  // direct fixnum
    localparam logic [DATA_SZ-1:0] MUT_TAG = 16'h4000;  // mutable memory
    localparam logic [DATA_SZ-1:0] OPQ_TAG = 16'h2000;  // opaque word
    localparam logic [DATA_SZ-1:0] VLT_TAG = 16'h1000;  // volatile memory
    localparam logic [DATA_SZ-1:0] PTR_TAGS = MUT_TAG | VLT_TAG;  // every heap pointer

    // reserved constants
    localparam logic [DATA_SZ-1:0] UNDEF = 16'h0000;    // o_addr after reset
    localparam logic [DATA_SZ-1:0] NIL   = 16'h0001;    // empty free list, no mut tag
    localparam logic [DATA_SZ-1:0] TRUE  = 16'h0002;
    localparam logic [DATA_SZ-1:0] FALSE = 16'h0003;
    localparam logic [DATA_SZ-1:0] UNIT  = 16'h0004;    // inert result
    localparam logic [DATA_SZ-1:0] ZERO  = 16'h8000;    // fixnum +0

    // controller states
    localparam logic ST_RUN  = 1'b0;               // serving requests
    localparam logic ST_HALT = 1'b1;               // stopped on error

    // one word, seen raw or as a pointer
    typedef union packed {
        logic [DATA_SZ-1:0] raw;                   // plain value
        struct packed {
            logic               dir;               // bit 15
            logic               mut;               // bit 14
            logic               opq;               // bit 13
            logic               vlt;               // bit 12
            logic [3:0]         rsvd;              // unused by the heap
            logic [ADDR_SZ-1:0] index;             // cell number
        } ptr;
    } heap_word_u;

endpackage

// ==== source/heap_bram.sv ====
////////////////////
// heap RAM
// 256 x 16 storage, one write and one registered read per clock
////////////////////

`timescale 1ns/1ps

module heap_bram (
    input  logic                         i_clk,
    input  logic                         i_arst_n,  // clears read register only
    input  logic                         i_we,
    input  logic [heap_pkg::ADDR_SZ-1:0] i_waddr,
    input  logic [heap_pkg::DATA_SZ-1:0] i_wdata,
    input  logic                         i_re,
    input  logic [heap_pkg::ADDR_SZ-1:0] i_raddr,
    output logic [heap_pkg::DATA_SZ-1:0] o_rdata   // holds when not reading
);

    import heap_pkg::*;

    logic [DATA_SZ-1:0] mem [MEM_MAX];

    always_ff @(posedge i_clk) begin
        if (i_we)
            mem[i_waddr] <= i_wdata;
    end

    // same-cell read during write sees old data
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            o_rdata <= '0;
        else if (i_re)
            o_rdata <= mem[i_raddr];
    end

endmodule

// ==== source/heap_counter.sv ====
////////////////////
// heap counters
// bump pointer with overflow bit, and the live-cell count
////////////////////

`timescale 1ns/1ps

module heap_counter (
    input  logic                       i_clk,
    input  logic                       i_arst_n,
    input  logic                       i_al_bump,    // cell taken from the top
    input  logic                       i_al_list,    // cell taken from the free list
    input  logic                       i_fr_en,      // cell returned
    output logic [heap_pkg::ADDR_SZ:0] o_top_index,  // next fresh cell
    output logic                       o_heap_full,
    output logic [heap_pkg::ADDR_SZ:0] o_used        // live cells
);

    import heap_pkg::*;

    logic [ADDR_SZ:0] top_q;                       // msb is overflow
    logic [ADDR_SZ:0] used_q;

    // bump pointer only grows
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            top_q <= '0;
        else if (i_al_bump)
            top_q <= top_q + 1'b1;
    end

    // count changes only on single alloc or free
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            used_q <= '0;
        end else begin
            if (i_al_bump || i_al_list)
                used_q <= used_q + 1'b1;
            else if (i_fr_en)
                used_q <= used_q - 1'b1;
        end
    end

    assign o_top_index = top_q;
    assign o_heap_full = top_q[ADDR_SZ];           // all cells handed out
    assign o_used      = used_q;

endmodule

// ==== source/heap_free_list.sv ====
////////////////////
// heap free list
// head and link registers of the free list, allocated
// address output, and RAM address and data steering
////////////////////

`timescale 1ns/1ps

module heap_free_list (
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  logic                         i_al_list,    // alloc from list head
    input  logic                         i_al_bump,    // alloc from bump pointer
    input  logic                         i_al_pass,    // freed cell handed back out
    input  logic                         i_fr_en,      // free only
    input  logic                         i_rd_en,      // memory port read
    input  logic                         i_wr_en,      // memory port write
    input  heap_pkg::heap_word_u         i_data,       // initial cell value
    input  heap_pkg::heap_word_u         i_addr,
    input  heap_pkg::heap_word_u         i_waddr,
    input  heap_pkg::heap_word_u         i_wdata,
    input  heap_pkg::heap_word_u         i_raddr,
    input  logic [heap_pkg::ADDR_SZ:0]   i_top_index,
    input  logic [heap_pkg::DATA_SZ-1:0] i_rdata,      // ram output
    output heap_pkg::heap_word_u         o_addr,
    output logic                         o_list_empty,
    output logic                         o_ram_we,
    output logic [heap_pkg::ADDR_SZ-1:0] o_ram_waddr,
    output logic [heap_pkg::DATA_SZ-1:0] o_ram_wdata,
    output logic                         o_ram_re,
    output logic [heap_pkg::ADDR_SZ-1:0] o_ram_raddr
);

    import heap_pkg::*;

    heap_word_u head_q;                            // next cell to hand out
    heap_word_u link_q;                            // cell after head
    logic       link_rd_q;                         // link sits on ram output
    heap_word_u link;                              // current link
    heap_word_u bump_addr;                         // fresh cell as pointer

    assign link = link_rd_q ? heap_word_u'(i_rdata) : link_q;

    assign o_list_empty = !head_q.ptr.mut;         // NIL carries no mut tag

    always_comb begin
        bump_addr           = heap_word_u'(PTR_TAGS);
        bump_addr.ptr.index = i_top_index[ADDR_SZ-1:0];
    end

    // list registers
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q    <= heap_word_u'(NIL);
            link_q    <= heap_word_u'(NIL);
            link_rd_q <= 1'b0;
        end else begin
            if (link_rd_q) begin                   // catch link before rdata moves
                link_q    <= heap_word_u'(i_rdata);
                link_rd_q <= 1'b0;
            end
            if (i_al_list) begin
                head_q    <= link;                 // pop
                link_rd_q <= 1'b1;                 // next link read this cycle
            end else if (i_fr_en) begin
                head_q    <= i_addr;               // push
                link_q    <= head_q;
                link_rd_q <= 1'b0;
            end
        end
    end

    // allocated address
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            o_addr <= heap_word_u'(UNDEF);
        else if (i_al_list)
            o_addr <= head_q;
        else if (i_al_bump)
            o_addr <= bump_addr;
        else if (i_al_pass)
            o_addr <= i_addr;                      // freed cell reused at once
    end

    // ram write side
    always_comb begin
        o_ram_we    = i_al_list || i_al_bump || i_al_pass || i_fr_en || i_wr_en;
        o_ram_waddr = i_waddr.ptr.index;
        o_ram_wdata = i_data.raw;                  // allocs store initial data
        if (i_wr_en) begin
            o_ram_wdata = i_wdata.raw;
        end else if (i_fr_en) begin
            o_ram_waddr = i_addr.ptr.index;
            o_ram_wdata = head_q.raw;              // old head linked in
        end else if (i_al_pass) begin
            o_ram_waddr = i_addr.ptr.index;
        end else if (i_al_list) begin
            o_ram_waddr = head_q.ptr.index;
        end else if (i_al_bump) begin
            o_ram_waddr = bump_addr.ptr.index;
        end
    end

    // ram read side, link fetch on list alloc
    assign o_ram_re    = i_rd_en || i_al_list;
    assign o_ram_raddr = i_rd_en ? i_raddr.ptr.index : link.ptr.index;

endmodule

// ==== source/heap_ctrl.sv ====
////////////////////
// heap controller
// decodes each request, judges legality and drives one-hot
// move and memory enables; halts on the first illegal request
////////////////////

`timescale 1ns/1ps

module heap_ctrl (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic                     i_alloc,       // pointer port
    input  logic                     i_free,
    input  logic                     i_rd,          // memory port
    input  logic                     i_wr,
    input  heap_pkg::heap_word_u     i_addr,        // address to free
    input  heap_pkg::heap_word_u     i_waddr,
    input  heap_pkg::heap_word_u     i_raddr,
    input  logic                     i_list_empty,  // from free list
    input  logic                     i_heap_full,   // from counter
    input  logic [heap_pkg::ADDR_SZ:0] i_top_index,  // bump index, extra msb
    output logic                     o_al_list,
    output logic                     o_al_bump,
    output logic                     o_al_pass,
    output logic                     o_fr_en,
    output logic                     o_rd_en,
    output logic                     o_wr_en,
    output logic                     o_err
);

    import heap_pkg::*;

    logic state_q;                                 // RUN or HALT
    logic state_d;
    logic bad_req;                                 // illegal this cycle
    logic addr_ok;
    logic waddr_ok;
    logic raddr_ok;

    // heap pointer tags and index below the bump pointer
    function automatic logic in_heap(input heap_word_u w, input logic [ADDR_SZ:0] top);
        logic tags_ok;
        tags_ok = !w.ptr.dir && w.ptr.mut && !w.ptr.opq && w.ptr.vlt;
        return tags_ok && ({1'b0, w.ptr.index} < top);
    endfunction

    assign addr_ok  = in_heap(i_addr, i_top_index);
    assign waddr_ok = in_heap(i_waddr, i_top_index);
    assign raddr_ok = in_heap(i_raddr, i_top_index);

    always_comb begin
        o_al_list = 1'b0;
        o_al_bump = 1'b0;
        o_al_pass = 1'b0;
        o_fr_en   = 1'b0;
        o_rd_en   = 1'b0;
        o_wr_en   = 1'b0;
        bad_req   = 1'b0;
        if (state_q == ST_RUN) begin               // halt drives nothing
            case ({i_alloc, i_free, i_rd, i_wr})
                4'b0000: ;                         // idle
                4'b1000: begin                     // alloc alone
                    if (!i_list_empty)
                        o_al_list = 1'b1;          // reuse freed cell first
                    else if (!i_heap_full)
                        o_al_bump = 1'b1;
                    else
                        bad_req = 1'b1;            // out of memory
                end
                4'b1100: if (addr_ok) o_al_pass = 1'b1; else bad_req = 1'b1;
                4'b0100: if (addr_ok) o_fr_en = 1'b1; else bad_req = 1'b1;
                4'b0010: if (raddr_ok) o_rd_en = 1'b1; else bad_req = 1'b1;
                4'b0001: if (waddr_ok) o_wr_en = 1'b1; else bad_req = 1'b1;
                4'b0011: begin                     // read and write together
                    if (raddr_ok && waddr_ok) begin
                        o_rd_en = 1'b1;
                        o_wr_en = 1'b1;
                    end else begin
                        bad_req = 1'b1;
                    end
                end
                default: bad_req = 1'b1;           // both ports in one cycle
            endcase
        end
    end

    assign state_d = bad_req ? ST_HALT : state_q;  // halt is left only by reset

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            state_q <= ST_RUN;
        else
            state_q <= state_d;
    end

    assign o_err = (state_q == ST_HALT);

endmodule

// ==== source/heap_alloc.sv ====
////////////////////
// heap allocator top
// pointer port for alloc/free, memory port for read/write,
// free list plus bump pointer over one 256-cell RAM
////////////////////

`timescale 1ns/1ps

module heap_alloc (
    input  logic                         i_clk,
    input  logic                         i_arst_n,
    input  logic                         i_alloc,   // pointer port
    input  heap_pkg::heap_word_u         i_data,
    input  logic                         i_free,
    input  heap_pkg::heap_word_u         i_addr,
    input  logic                         i_wr,      // memory port
    input  heap_pkg::heap_word_u         i_waddr,
    input  heap_pkg::heap_word_u         i_wdata,
    input  logic                         i_rd,
    input  heap_pkg::heap_word_u         i_raddr,
    output heap_pkg::heap_word_u         o_addr,    // last allocated cell
    output logic [heap_pkg::DATA_SZ-1:0] o_rdata,
    output logic [heap_pkg::ADDR_SZ:0]   o_used,    // live cells
    output logic                         o_err      // sticky until reset
);

    import heap_pkg::*;

    logic               al_list;
    logic               al_bump;
    logic               al_pass;
    logic               fr_en;
    logic               rd_en;
    logic               wr_en;
    logic               list_empty;
    logic               heap_full;
    logic [ADDR_SZ:0]   top_index;
    logic               ram_we;
    logic [ADDR_SZ-1:0] ram_waddr;
    logic [DATA_SZ-1:0] ram_wdata;
    logic               ram_re;
    logic [ADDR_SZ-1:0] ram_raddr;

    heap_ctrl u_ctrl (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_alloc(i_alloc), .i_free(i_free), .i_rd(i_rd), .i_wr(i_wr),
        .i_addr(i_addr), .i_waddr(i_waddr), .i_raddr(i_raddr),
        .i_list_empty(list_empty), .i_heap_full(heap_full), .i_top_index(top_index),
        .o_al_list(al_list), .o_al_bump(al_bump), .o_al_pass(al_pass),
        .o_fr_en(fr_en), .o_rd_en(rd_en), .o_wr_en(wr_en), .o_err(o_err)
    );

    heap_counter u_counter (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_al_bump(al_bump), .i_al_list(al_list), .i_fr_en(fr_en),
        .o_top_index(top_index), .o_heap_full(heap_full), .o_used(o_used)
    );

    heap_free_list u_free_list (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_al_list(al_list), .i_al_bump(al_bump), .i_al_pass(al_pass),
        .i_fr_en(fr_en), .i_rd_en(rd_en), .i_wr_en(wr_en),
        .i_data(i_data), .i_addr(i_addr), .i_waddr(i_waddr),
        .i_wdata(i_wdata), .i_raddr(i_raddr),
        .i_top_index(top_index), .i_rdata(o_rdata),
        .o_addr(o_addr), .o_list_empty(list_empty),
        .o_ram_we(ram_we), .o_ram_waddr(ram_waddr), .o_ram_wdata(ram_wdata),
        .o_ram_re(ram_re), .o_ram_raddr(ram_raddr)
    );

    heap_bram u_bram (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_we(ram_we), .i_waddr(ram_waddr), .i_wdata(ram_wdata),
        .i_re(ram_re), .i_raddr(ram_raddr),
        .o_rdata(o_rdata)                           // also feeds the link fetch
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
////////////////////
// testbench clock and reset
// 20 ns clock, reset held low for 3 rising edges
////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
    input  logic i_rst_req,                        // level, asks for a new reset
    output logic o_clk,
    output logic o_arst_n
);

    localparam int HALF_PERIOD = 10;               // ns

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_arst_n = 1'b0;                           // in reset from time 0
        forever begin
            repeat (3) @(posedge o_clk);
            #2 o_arst_n = 1'b1;                    // release off the edge
            wait (i_rst_req);
            o_arst_n = 1'b0;                       // async assert
        end
    end

endmodule

// ==== sim/heap_alloc_assertions.sv ====
////////////////////
// heap controller checks
// enable exclusivity, sticky halt, quiet halt and quiet reset
////////////////////

`timescale 1ns/1ps

module heap_alloc_assertions (
    input logic i_clk,
    input logic i_arst_n,
    input logic o_al_list,
    input logic o_al_bump,
    input logic o_al_pass,
    input logic o_fr_en,
    input logic o_rd_en,
    input logic o_wr_en,
    input logic o_err
);

    logic any_move;
    logic mem_access;
    int   failures = 0;                            // assertion failures so far

    assign any_move   = o_al_list | o_al_bump | o_al_pass | o_fr_en;
    assign mem_access = o_rd_en | o_wr_en;         // read plus write is one memory access

    a_one_enable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({o_al_list, o_al_bump, o_al_pass, o_fr_en, mem_access}))
        else begin
            failures++;
            $error("more than one heap enable active at once");
        end

    a_err_sticky: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_err |=> o_err)
        else begin
            failures++;
            $error("o_err dropped without a reset");
        end

    a_halt_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_err |-> !(any_move || mem_access))
        else begin
            failures++;
            $error("enable active while halted");
        end

    a_reset_quiet: assert property (@(posedge i_clk)
        $rose(i_arst_n) |-> !any_move)             // first cycle out of reset
        else begin
            failures++;
            $error("move enable active in the first cycle after reset");
        end

endmodule

// ==== sim/tb_heap_alloc.sv ====
////////////////////
// heap allocator testbench
// directed tests against a reference model of bump index,
// LIFO free list, memory contents and live count
////////////////////

`timescale 1ns/1ps

module tb_heap_alloc;

    import heap_pkg::*;

    localparam int RESET_CYCLES = 5;               // request, 3 held, 1 quiet
    localparam int TEST_CYCLES  = 5 * RESET_CYCLES + 60 + MEM_MAX;
    localparam int CYCLE_LIMIT  = TEST_CYCLES + 100;

    logic         clk;
    logic         arst_n;
    logic         rst_req;
    logic         req_alloc;
    logic         req_free;
    logic         req_rd;
    logic         req_wr;
    logic [15:0]  req_data;
    logic [15:0]  req_addr;
    logic [15:0]  req_raddr;
    logic [15:0]  req_waddr;
    logic [15:0]  req_wdata;
    logic [15:0]  got_addr;
    logic [15:0]  got_rdata;
    logic [8:0]   got_used;
    logic         got_err;

    int           cycles = 0;
    int           checks;
    int           mismatches;
    int           others;                          // failures that are not value compares
    logic [31:0]  lfsr;
    int           model_top;                       // bump index
    int           model_used;
    logic [15:0]  model_addr;                      // last alloc result
    logic [15:0]  free_q [$];                      // back is the list head
    logic [15:0]  model_mem [MEM_MAX];

    tb_clock_gen u_clk_gen (.i_rst_req(rst_req), .o_clk(clk), .o_arst_n(arst_n));

    heap_alloc dut (
        .i_clk(clk), .i_arst_n(arst_n),
        .i_alloc(req_alloc), .i_data(req_data), .i_free(req_free), .i_addr(req_addr),
        .i_wr(req_wr), .i_waddr(req_waddr), .i_wdata(req_wdata),
        .i_rd(req_rd), .i_raddr(req_raddr),
        .o_addr(got_addr), .o_rdata(got_rdata), .o_used(got_used), .o_err(got_err)
    );

    bind heap_ctrl heap_alloc_assertions u_assertions (.*);

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // galois lfsr over x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output logic [15:0] w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);                // one step per bit
            w    = {w[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] ptr(input int idx);
        return PTR_TAGS | 16'(idx);
    endfunction

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_err(input logic exp);
        checks++;
        assert (got_err === exp) else begin
            others++;
            if (exp)
                $display("error at %0t: o_err did not rise after an illegal request", $time);
            else
                $display("error at %0t: o_err is high after legal requests", $time);
        end
    endtask

    task automatic check_outputs();
        check_word("o_addr", got_addr, model_addr);
        check_word("o_used", {7'b0, got_used}, 16'(model_used));
        check_err(1'b0);
    endtask

    task automatic apply_inputs(input logic a, input logic f, input logic r, input logic w,
                                input logic [15:0] d, input logic [15:0] ad,
                                input logic [15:0] ra, input logic [15:0] wa,
                                input logic [15:0] wd);
        req_alloc = a;
        req_free  = f;
        req_rd    = r;
        req_wr    = w;
        req_data  = d;
        req_addr  = ad;
        req_raddr = ra;
        req_waddr = wa;
        req_wdata = wd;
    endtask

    // entered at edge+1, drives at edge+2, returns at next edge+1
    task automatic issue_request(input logic a, input logic f, input logic r, input logic w,
                                 input logic [15:0] d, input logic [15:0] ad,
                                 input logic [15:0] ra, input logic [15:0] wa,
                                 input logic [15:0] wd);
        #1;
        apply_inputs(a, f, r, w, d, ad, ra, wa, wd);
        @(posedge clk);
        #1;
    endtask

    task automatic reset_dut();
        #1;
        apply_inputs(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0, '0, '0);
        rst_req = 1'b1;
        wait (arst_n === 1'b0);
        rst_req = 1'b0;
        wait (arst_n === 1'b1);
        @(posedge clk);                            // quiet first cycle
        #1;
        model_top  = 0;
        model_used = 0;
        model_addr = UNDEF;
        free_q.delete();                           // ram contents survive reset
        check_outputs();
        check_word("o_rdata", got_rdata, 16'h0000);
    endtask

    task automatic alloc_cell(input logic [15:0] d);
        if (free_q.size() > 0) begin
            model_addr = free_q.pop_back();        // LIFO reuse
        end else begin
            model_addr = ptr(model_top);
            model_top++;
        end
        model_used++;
        model_mem[model_addr[ADDR_SZ-1:0]] = d;
        issue_request(1'b1, 1'b0, 1'b0, 1'b0, d, '0, '0, '0, '0);
        check_outputs();
    endtask

    task automatic free_cell(input logic [15:0] a);
        model_mem[a[ADDR_SZ-1:0]] = (free_q.size() > 0) ? free_q[$] : NIL;  // old head
        free_q.push_back(a);
        model_used--;
        issue_request(1'b0, 1'b1, 1'b0, 1'b0, '0, a, '0, '0, '0);
        check_outputs();
    endtask

    task automatic pass_cell(input logic [15:0] d, input logic [15:0] a);
        model_addr = a;                            // count unchanged
        model_mem[a[ADDR_SZ-1:0]] = d;
        issue_request(1'b1, 1'b1, 1'b0, 1'b0, d, a, '0, '0, '0);
        check_outputs();
    endtask

    task automatic write_cell(input logic [15:0] wa, input logic [15:0] wd);
        model_mem[wa[ADDR_SZ-1:0]] = wd;
        issue_request(1'b0, 1'b0, 1'b0, 1'b1, '0, '0, '0, wa, wd);
        check_outputs();
    endtask

    task automatic read_write(input logic r, input logic [15:0] ra,
                              input logic w, input logic [15:0] wa, input logic [15:0] wd);
        logic [15:0] exp;
        exp = model_mem[ra[ADDR_SZ-1:0]];          // old data on same-cell write
        if (w)
            model_mem[wa[ADDR_SZ-1:0]] = wd;
        issue_request(1'b0, 1'b0, r, w, '0, '0, ra, wa, wd);
        check_outputs();
        check_word("o_rdata", got_rdata, exp);
    endtask

    task automatic expect_halt(input logic a, input logic f, input logic r,
                               input logic [15:0] ad, input logic [15:0] ra);
        logic [15:0] d;
        random_word(d);
        issue_request(a, f, r, 1'b0, d, ad, ra, '0, '0);
        check_err(1'b1);
        random_word(d);
        issue_request(1'b1, 1'b0, 1'b0, 1'b0, d, '0, '0, '0, '0);  // must be ignored
        check_word("o_addr", got_addr, model_addr);
        check_word("o_used", {7'b0, got_used}, 16'(model_used));
        check_err(1'b1);
    endtask

    task automatic alloc_random(input int n);
        logic [15:0] d;
        for (int i = 0; i < n; i++) begin
            random_word(d);
            alloc_cell(d);
        end
    endtask

    task automatic bump_allocation();
        reset_dut();
        alloc_random(6);                           // indices 0 to 5
    endtask

    task automatic free_list_reuse();
        free_cell(ptr(1));
        free_cell(ptr(3));
        free_cell(ptr(4));
        alloc_random(3);                           // back as 4, 3, 1
        read_write(1'b1, ptr(4), 1'b0, '0, '0);
        read_write(1'b1, ptr(3), 1'b0, '0, '0);
        read_write(1'b1, ptr(1), 1'b0, '0, '0);
        alloc_random(1);                           // list now empty so bump again
    endtask

    task automatic memory_port_access();
        logic [15:0] d;
        random_word(d);
        write_cell(ptr(0), d);
        random_word(d);
        write_cell(ptr(2), d);
        read_write(1'b1, ptr(0), 1'b0, '0, '0);
        read_write(1'b1, ptr(2), 1'b0, '0, '0);
        random_word(d);
        read_write(1'b1, ptr(0), 1'b1, ptr(0), d); // same cell returns old data
        read_write(1'b1, ptr(0), 1'b0, '0, '0);
        random_word(d);
        read_write(1'b1, ptr(2), 1'b1, ptr(5), d);
        read_write(1'b1, ptr(5), 1'b0, '0, '0);
    endtask

    task automatic alloc_free_pass();
        logic [15:0] d;
        random_word(d);
        pass_cell(d, ptr(2));
        read_write(1'b1, ptr(2), 1'b0, '0, '0);
        free_cell(ptr(5));
        random_word(d);
        pass_cell(d, ptr(0));                      // list head untouched
        alloc_random(1);                           // takes cell 5
    endtask

    task automatic error_halts();
        reset_dut();
        alloc_random(2);
        expect_halt(1'b1, 1'b0, 1'b1, '0, ptr(0)); // both ports
        reset_dut();
        alloc_random(1);
        expect_halt(1'b0, 1'b1, 1'b0, ZERO, '0);   // free of a fixnum
        reset_dut();
        alloc_random(2);
        expect_halt(1'b0, 1'b0, 1'b1, '0, ptr(5)); // above bump index
        reset_dut();
        alloc_random(MEM_MAX);
        expect_halt(1'b1, 1'b0, 1'b0, '0, '0);     // heap exhausted
    endtask

    initial begin
        apply_inputs(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0, '0, '0);
        rst_req    = 1'b0;
        lfsr       = 32'h23;
        checks     = 0;
        mismatches = 0;
        others     = 0;
        bump_allocation();
        free_list_reuse();
        memory_port_access();
        alloc_free_pass();
        error_halts();
        $display("summary: %0d checks, %0d mismatches, %0d other, %0d assertion failures",
                 checks, mismatches, others, dut.u_ctrl.u_assertions.failures);
        if (mismatches == 0 && others == 0 && dut.u_ctrl.u_assertions.failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== heap_alloc.f ====
source/heap_pkg.sv
source/heap_bram.sv
source/heap_counter.sv
source/heap_free_list.sv
source/heap_ctrl.sv
source/heap_alloc.sv
sim/tb_clock_gen.sv
sim/heap_alloc_assertions.sv
sim/tb_heap_alloc.sv

// ==== Bender.yml ====
package:
  name: heap_alloc

sources:
  # design
  - target: any(rtl, simulation)
    files:
      - source/heap_pkg.sv
      - source/heap_bram.sv
      - source/heap_counter.sv
      - source/heap_free_list.sv
      - source/heap_ctrl.sv
      - source/heap_alloc.sv
  # testbench
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/heap_alloc_assertions.sv
      - sim/tb_heap_alloc.sv
